//--- div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// --------------------
// Datapath sizing
// --------------------

// Operand and result width of the RV32 core
`define DIV_XLEN 32

// --------------------
// Accuracy control
// --------------------

// Number of low quotient bits that software may switch off
`define DIV_ER_WIDTH 8

// Lowest bit of the mask field inside accuracy_control
// Bit 0 of the same register turns the mask on
`define DIV_ER_LSB 3

`endif

//--- div_pkg.sv
`include "div_settings.svh"

package div_pkg;

  // --------------------
  // Plain vector types
  // --------------------
  typedef logic [`DIV_XLEN-1:0]     word_t;     // Operand or result word
  typedef logic [`DIV_ER_WIDTH-1:0] er_mask_t;  // Bit i enables quotient bit i
  typedef logic [6:0]               opcode_t;   // Major opcode field
  typedef logic [6:0]               funct7_t;   // Upper function field
  typedef logic [2:0]               funct3_t;   // Minor function field
  typedef logic [1:0]               div_op_t;   // Low two bits of funct3

  // Divide encodings of the M extension
  localparam opcode_t OPCODE_OP     = 7'b0110011;  // Register to register ops
  localparam funct7_t FUNCT7_MULDIV = 7'b0000001;  // MUL and DIV group

  localparam div_op_t OP_DIV  = 2'b00;  // funct3 100
  localparam div_op_t OP_DIVU = 2'b01;  // funct3 101
  localparam div_op_t OP_REM  = 2'b10;  // funct3 110
  localparam div_op_t OP_REMU = 2'b11;  // funct3 111

  localparam word_t MIN_WORD = {1'b1, {(`DIV_XLEN-1){1'b0}}};  // Most negative value

  // Iterating stage FSM
  typedef enum logic [1:0] {
    IDLE,  // Waiting for an item
    RUN,   // One quotient bit per cycle
    DONE   // Raw result offered downstream
  } div_state_t;

  // --------------------
  // Stage payloads
  // --------------------
  typedef struct packed {
    opcode_t opcode;
    funct7_t funct7;
    funct3_t funct3;
    word_t   accuracy_control;  // Approximation control register
    word_t   rs1;               // Dividend
    word_t   rs2;               // Divisor
  } div_req_t;

  typedef struct packed {
    word_t    dividend_mag;
    word_t    divisor_mag;
    logic     neg_quot;      // Signs differ on a signed op
    logic     neg_rem;       // Dividend negative on a signed op
    logic     sel_rem;       // REM or REMU
    logic     special;       // Zero divisor or signed overflow
    word_t    special_quot;
    word_t    special_rem;
    logic     illegal;       // Not a divide instruction
    er_mask_t er_mask;
  } div_operands_t;

  typedef struct packed {
    word_t quot_mag;
    word_t rem_mag;
    logic  neg_quot;
    logic  neg_rem;
    logic  sel_rem;
    logic  special;
    word_t special_quot;
    word_t special_rem;
    logic  illegal;
  } div_raw_t;

  typedef struct packed {
    word_t result;   // Quotient or remainder
    logic  illegal;  // Set with a zero result
  } div_resp_t;

endpackage

//--- div_decode.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_decode import div_pkg::*; (
  input  logic          CLK,
  input  logic          reset,
  input  logic          req_valid,
  output logic          req_ready,
  input  div_req_t      req,
  output logic          op_valid,
  input  logic          op_ready,
  output div_operands_t op
);

  div_op_t       op_code;    // Operation taken from funct3
  logic          legal;      // Fields name a divide
  logic          is_signed;  // DIV or REM
  logic          sign_1;     // Dividend negative
  logic          sign_2;     // Divisor negative
  logic          div_zero;
  logic          overflow;   // MIN_WORD divided by minus one
  er_mask_t      er_mask;
  div_operands_t op_next;

  // --------------------
  // Instruction decode
  // --------------------
  assign legal = (req.opcode == OPCODE_OP) &&
                 (req.funct7 == FUNCT7_MULDIV) &&
                 req.funct3[2];                       // Upper half of funct3 space
  assign op_code   = req.funct3[1:0];                 // Encodings follow funct3 directly
  assign is_signed = (op_code == OP_DIV) || (op_code == OP_REM);

  // Signs only count for signed ops
  assign sign_1 = is_signed && req.rs1[`DIV_XLEN-1];
  assign sign_2 = is_signed && req.rs2[`DIV_XLEN-1];

  // Special cases of the RISC-V division rules
  assign div_zero = (req.rs2 == '0);
  assign overflow = is_signed && (req.rs1 == MIN_WORD) && (req.rs2 == '1);

  // Exact unless bit 0 of accuracy_control is set
  assign er_mask = req.accuracy_control[0] ?
                   req.accuracy_control[`DIV_ER_LSB +: `DIV_ER_WIDTH] : '1;

  // --------------------
  // Operand forming
  // --------------------
  always_comb begin
    op_next              = '0;
    op_next.dividend_mag = sign_1 ? -req.rs1 : req.rs1;  // Magnitudes only downstream
    op_next.divisor_mag  = sign_2 ? -req.rs2 : req.rs2;
    op_next.neg_quot     = sign_1 ^ sign_2;
    op_next.neg_rem      = sign_1;                        // Remainder follows dividend
    op_next.sel_rem      = (op_code == OP_REM) || (op_code == OP_REMU);
    op_next.special      = legal && (div_zero || overflow);
    op_next.illegal      = !legal;
    op_next.er_mask      = er_mask;
    if (div_zero) begin
      op_next.special_quot = '1;       // All ones for any op
      op_next.special_rem  = req.rs1;  // Dividend unchanged
    end else begin
      op_next.special_quot = MIN_WORD; // Overflow wraps back
      op_next.special_rem  = '0;
    end
  end

  // --------------------
  // Output slot
  // --------------------
  assign req_ready = !op_valid || op_ready;  // Empty or being drained

  always_ff @(posedge CLK) begin
    if (reset) begin
      op_valid <= 1'b0;
    end else if (req_valid && req_ready) begin
      op_valid <= 1'b1;
    end else if (op_ready) begin
      op_valid <= 1'b0;  // Taken with nothing behind
    end
  end

  always_ff @(posedge CLK) begin
    if (req_valid && req_ready) begin
      op <= op_next;
    end
  end

endmodule

//--- div_iterative.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_iterative import div_pkg::*; (
  input  logic          CLK,
  input  logic          reset,
  input  logic          op_valid,
  output logic          op_ready,
  input  div_operands_t op,
  output logic          raw_valid,
  input  logic          raw_ready,
  output div_raw_t      raw
);

  localparam int unsigned CNT_W    = $clog2(`DIV_XLEN);      // Bit index width
  localparam int unsigned ER_IDX_W = $clog2(`DIV_ER_WIDTH);  // Mask index width

  div_state_t         state;
  logic [CNT_W-1:0]   bit_cnt;     // Quotient bit being produced
  word_t              dividend_q;
  word_t              divisor_q;
  er_mask_t           mask_q;
  logic               bypass;      // Special or illegal item
  logic               bit_en;      // Iteration allowed by the mask
  logic [`DIV_XLEN:0] shifted;     // Partial remainder with next dividend bit
  logic [`DIV_XLEN:0] diff;        // Trial subtraction
  logic               take;        // Divisor fits

  // --------------------
  // Handshake
  // --------------------
  assign op_ready  = (state == IDLE);
  assign raw_valid = (state == DONE);
  assign bypass    = raw.special || raw.illegal;

  // --------------------
  // One restoring step
  // --------------------
  assign bit_en  = (bit_cnt >= CNT_W'(`DIV_ER_WIDTH)) ||
                   mask_q[bit_cnt[ER_IDX_W-1:0]];       // Only low bits are maskable
  assign shifted = {raw.rem_mag, dividend_q[bit_cnt]};
  assign diff    = shifted - {1'b0, divisor_q};
  assign take    = bit_en && !diff[`DIV_XLEN];          // No borrow means it fits

  // Control FSM
  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (op_valid) begin
            state   <= RUN;
            bit_cnt <= CNT_W'(`DIV_XLEN - 1);  // Start from the MSB
          end
        end
        RUN: begin
          if (bypass || (bit_cnt == '0)) begin
            state <= DONE;                     // Specials leave after one cycle
          end
          bit_cnt <= bit_cnt - 1'b1;
        end
        DONE: begin
          if (raw_ready) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge CLK) begin
    if ((state == IDLE) && op_valid) begin
      dividend_q       <= op.dividend_mag;
      divisor_q        <= op.divisor_mag;
      mask_q           <= op.er_mask;
      raw.quot_mag     <= '0;
      raw.rem_mag      <= '0;               // Partial remainder starts empty
      raw.neg_quot     <= op.neg_quot;      // Flags ride along with the item
      raw.neg_rem      <= op.neg_rem;
      raw.sel_rem      <= op.sel_rem;
      raw.special      <= op.special;
      raw.special_quot <= op.special_quot;
      raw.special_rem  <= op.special_rem;
      raw.illegal      <= op.illegal;
    end else if ((state == RUN) && !bypass) begin
      raw.quot_mag[bit_cnt] <= take;
      // Skipped bits keep the shifted value and grow past the divisor
      raw.rem_mag <= take ? diff[`DIV_XLEN-1:0] : shifted[`DIV_XLEN-1:0];
    end
  end

endmodule

//--- div_result.sv
`timescale 1ns/1ps

module div_result import div_pkg::*; (
  input  logic      CLK,
  input  logic      reset,
  input  logic      raw_valid,
  output logic      raw_ready,
  input  div_raw_t  raw,
  output logic      resp_valid,
  input  logic      resp_ready,
  output div_resp_t resp
);

  word_t     quot_signed;  // Quotient with sign applied
  word_t     rem_signed;   // Remainder with sign applied
  word_t     quot_final;
  word_t     rem_final;
  div_resp_t resp_next;

  // --------------------
  // Sign and special cases
  // --------------------
  assign quot_signed = raw.neg_quot ? -raw.quot_mag : raw.quot_mag;
  assign rem_signed  = raw.neg_rem ? -raw.rem_mag : raw.rem_mag;

  assign quot_final = raw.special ? raw.special_quot : quot_signed;
  assign rem_final  = raw.special ? raw.special_rem : rem_signed;

  always_comb begin
    resp_next.illegal = raw.illegal;
    if (raw.illegal) begin
      resp_next.result = '0;          // Nothing meaningful to return
    end else if (raw.sel_rem) begin
      resp_next.result = rem_final;   // REM and REMU
    end else begin
      resp_next.result = quot_final;  // DIV and DIVU
    end
  end

  // --------------------
  // Response register
  // --------------------
  assign raw_ready = !resp_valid || resp_ready;

  always_ff @(posedge CLK) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else if (raw_valid && raw_ready) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;  // Accepted downstream
    end
  end

  always_ff @(posedge CLK) begin
    if (raw_valid && raw_ready) begin
      resp <= resp_next;
    end
  end

endmodule

//--- divider_unit.sv
`timescale 1ns/1ps

module divider_unit import div_pkg::*; (
  input  logic      CLK,
  input  logic      reset,
  input  logic      req_valid,
  output logic      req_ready,
  input  div_req_t  req,
  output logic      resp_valid,
  input  logic      resp_ready,
  output div_resp_t resp,
  output logic      busy
);

  logic          op_valid;   // Decode slot full
  logic          op_ready;   // Core idle
  div_operands_t op;
  logic          raw_valid;  // Core result offered
  logic          raw_ready;
  div_raw_t      raw;

  // --------------------
  // Pipeline stages
  // --------------------
  div_decode i_div_decode (
    .CLK       (CLK),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op        (op)
  );

  div_iterative i_div_iterative (
    .CLK       (CLK),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op        (op),
    .raw_valid (raw_valid),
    .raw_ready (raw_ready),
    .raw       (raw)
  );

  div_result i_div_result (
    .CLK        (CLK),
    .reset      (reset),
    .raw_valid  (raw_valid),
    .raw_ready  (raw_ready),
    .raw        (raw),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  // Core holds an item whenever it is out of IDLE
  assign busy = op_valid || !op_ready || resp_valid;

endmodule

//--- tb_divider_unit.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module tb_divider_unit import div_pkg::*;;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned SEED         = 32'h93c2_fdc2;
  localparam logic [2:0]  F3_DIV       = 3'b100;
  localparam logic [2:0]  F3_DIVU      = 3'b101;
  localparam logic [2:0]  F3_REM       = 3'b110;
  localparam logic [2:0]  F3_REMU      = 3'b111;
  localparam word_t       EXACT        = '0;      // Accuracy bit 0 cleared

  typedef struct packed {
    div_req_t req;
    logic     exp_illegal;  // Expected illegal flag
    logic     wait_idle;    // Start from an empty unit
    logic     stall;        // Random resp_ready drops
  } entry_t;

  logic      CLK;
  logic      reset;
  logic      req_valid;
  logic      req_ready;
  div_req_t  req;
  logic      resp_valid;
  logic      resp_ready;
  div_resp_t resp;
  logic      busy;

  entry_t    stim_q[$];         // Stimulus table
  word_t     exp_result_q[$];   // Expected results in order
  logic      exp_illegal_q[$];
  int        cur_idx;           // Entry on the request port
  int        outstanding;       // Accepted but not yet returned
  int        errors;
  int        sent;
  int        received;
  int        cycle;
  int        lat_start;
  int        lat_expect;
  logic      lat_armed;         // Timing the first response after idle
  logic      stall_on;

  divider_unit i_divider_unit (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // --------------------
  // Reference model
  // --------------------
  // fast marks items that bypass the iterations
  function automatic word_t model_div(input div_req_t r, output logic fast);
    logic               sgn;
    logic               n1;
    logic               n2;
    logic               en;
    word_t              a;
    word_t              b;
    word_t              q;
    word_t              rem;
    er_mask_t           m;
    logic [`DIV_XLEN:0] sh;
    int                 i;
    sgn  = !r.funct3[0];  // DIV and REM
    fast = 1'b1;
    if ((r.opcode != 7'h33) || (r.funct7 != 7'h01) || !r.funct3[2]) begin
      return '0;  // Not a divide
    end
    if (r.rs2 == '0) begin
      return r.funct3[1] ? r.rs1 : '1;  // Divide by zero
    end
    if (sgn && (r.rs1 == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (r.rs2 == '1)) begin
      return r.funct3[1] ? '0 : r.rs1;  // Signed overflow
    end
    fast = 1'b0;
    n1   = sgn && r.rs1[`DIV_XLEN-1];
    n2   = sgn && r.rs2[`DIV_XLEN-1];
    a    = n1 ? -r.rs1 : r.rs1;
    b    = n2 ? -r.rs2 : r.rs2;
    m    = r.accuracy_control[0] ? r.accuracy_control[`DIV_ER_LSB +: `DIV_ER_WIDTH] : '1;
    q    = '0;
    rem  = '0;
    for (i = `DIV_XLEN - 1; i >= 0; i--) begin
      sh = {rem, a[i]};
      en = (i >= `DIV_ER_WIDTH) ? 1'b1 : m[i];  // Only low bits can be skipped
      if (en && (sh >= {1'b0, b})) begin
        rem  = word_t'(sh - b);
        q[i] = 1'b1;
      end else begin
        rem = sh[`DIV_XLEN-1:0];  // Partial remainder kept in one word
      end
    end
    q   = (n1 ^ n2) ? -q : q;
    rem = n1 ? -rem : rem;   // Sign of the dividend
    return r.funct3[1] ? rem : q;
  endfunction

  task automatic add_entry(input logic [6:0] opcode, input logic [6:0] funct7,
                           input logic [2:0] funct3, input word_t acc, input word_t rs1,
                           input word_t rs2, input logic ill, input logic idle,
                           input logic stall);
    entry_t e;
    e.req         = '{opcode, funct7, funct3, acc, rs1, rs2};
    e.exp_illegal = ill;
    e.wait_idle   = idle;
    e.stall       = stall;
    stim_q.push_back(e);
  endtask

  task automatic add_div(input logic [2:0] funct3, input word_t acc, input word_t rs1,
                         input word_t rs2, input logic idle, input logic stall);
    add_entry(7'h33, 7'h01, funct3, acc, rs1, rs2, 1'b0, idle, stall);
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic build_table();
    // Exact results over all sign mixes
    add_div(F3_DIV,  EXACT, 32'd100, 32'd7, 1'b1, 1'b0);  // Timed from idle
    add_div(F3_DIV,  EXACT, -32'd100, 32'd7, 1'b0, 1'b0);
    add_div(F3_DIV,  EXACT, 32'd100, -32'd7, 1'b0, 1'b0);
    add_div(F3_DIV,  EXACT, -32'd100, -32'd7, 1'b0, 1'b0);
    add_div(F3_DIVU, EXACT, 32'hFFFF_FFF0, 32'd3, 1'b0, 1'b0);
    add_div(F3_REM,  EXACT, -32'd100, 32'd7, 1'b0, 1'b0);
    add_div(F3_REM,  EXACT, 32'd7, -32'd100, 1'b0, 1'b0);
    add_div(F3_REMU, EXACT, 32'hFFFF_FFFF, 32'h10, 1'b0, 1'b0);
    add_div(F3_DIV,  32'h0000_0528, 32'h7FFF_FFFF, 32'd3, 1'b0, 1'b0);  // Mask set, not enabled
    // Special cases
    add_div(F3_DIV,  EXACT, 32'h8000_1234, 32'd0, 1'b1, 1'b0);  // Short path timed
    add_div(F3_DIVU, EXACT, 32'h8000_1234, 32'd0, 1'b0, 1'b0);
    add_div(F3_REM,  EXACT, 32'h8000_1234, 32'd0, 1'b0, 1'b0);
    add_div(F3_REMU, EXACT, 32'h8000_1234, 32'd0, 1'b0, 1'b0);
    add_div(F3_DIV,  EXACT, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0);
    add_div(F3_REM,  EXACT, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0);
    add_div(F3_DIVU, EXACT, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 1'b0);  // Plain unsigned
    // Reduced accuracy
    add_div(F3_DIVU, 32'h0000_07F9, 32'd1000000, 32'd7, 1'b1, 1'b0);    // All ones
    add_div(F3_DIVU, 32'h0000_0001, 32'd1000000, 32'd7, 1'b0, 1'b0);    // All zeros
    add_div(F3_DIV,  32'h0000_0529, -32'd999999, 32'd13, 1'b0, 1'b0);   // Mask A5
    add_div(F3_REM,  32'h0000_0529, -32'd999999, 32'd13, 1'b0, 1'b0);
    add_div(F3_REMU, 32'h0000_0001, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0, 1'b0);
    // Not a divide
    add_entry(7'h13, 7'h01, 3'b100, EXACT, 32'd100, 32'd7, 1'b1, 1'b1, 1'b0);
    add_entry(7'h33, 7'h00, 3'b110, EXACT, 32'd100, 32'd7, 1'b1, 1'b0, 1'b0);
    add_entry(7'h33, 7'h01, 3'b011, EXACT, 32'd100, 32'd0, 1'b1, 1'b0, 1'b0);  // MULHU
    // Back to back under output stalls
    add_div(F3_DIV,  EXACT, 32'd123456789, 32'd321, 1'b0, 1'b1);
    add_div(F3_REMU, EXACT, 32'd123456789, 32'd321, 1'b0, 1'b1);
    add_div(F3_DIV,  EXACT, -32'd5, 32'd0, 1'b0, 1'b1);
    add_entry(7'h33, 7'h20, 3'b101, EXACT, 32'd9, 32'd3, 1'b1, 1'b0, 1'b1);
    add_div(F3_REM,  32'h0000_0311, -32'd77777, -32'd9, 1'b0, 1'b1);
    add_div(F3_REMU, 32'h0000_0409, 32'h7654_3210, 32'd1000, 1'b0, 1'b1);
  endtask

  // Random back-pressure on the output
  initial begin
    void'($urandom(SEED));
    resp_ready = 1'b1;
    forever begin
      @(posedge CLK);
      if (stall_on) begin
        resp_ready <= (($urandom % 4) != 0);  // About one cycle in four low
      end else begin
        resp_ready <= 1'b1;
      end
    end
  end

  // --------------------
  // Driver
  // --------------------
  initial begin
    int          idx;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    stall_on    = 1'b0;
    cur_idx     = 0;
    outstanding = 0;
    errors      = 0;
    sent        = 0;
    received    = 0;
    cycle       = 0;
    lat_armed   = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    assert (!resp_valid && !busy) else begin
      errors++;
      $display("[ERROR] %0t resp_valid/busy after reset: got %b/%b expected 0/0",
               $time, resp_valid, busy);
    end
    for (idx = 0; idx < stim_q.size(); idx++) begin
      if (stim_q[idx].wait_idle) begin
        @(posedge CLK);
        req_valid <= 1'b0;
        do begin
          @(negedge CLK);
        end while (busy);  // Let the unit drain
      end
      @(posedge CLK);
      req_valid <= 1'b1;
      req       <= stim_q[idx].req;
      cur_idx   <= idx;
      stall_on  <= stim_q[idx].stall;
      do begin
        @(negedge CLK);
      end while (!req_ready);  // Transfer on the next edge
    end
    @(posedge CLK);
    req_valid <= 1'b0;
    stall_on  <= 1'b0;
    do begin
      @(negedge CLK);
    end while (busy);
    assert ((received == stim_q.size()) && (exp_result_q.size() == 0)) else begin
      errors++;
      $display("Responses lost or repeated: %0d sent, %0d received", sent, received);
    end
    $display("Requests %0d, responses %0d, errors %0d", sent, received, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // --------------------
  // Monitor
  // --------------------
  always @(negedge CLK) begin
    word_t exp_res;
    logic  exp_ill;
    logic  fast;
    if (!reset) begin
      cycle++;
      assert (busy == (outstanding != 0)) else begin
        errors++;
        $display("[ERROR] %0t busy: got %b expected %b", $time, busy, outstanding != 0);
      end
      // One slot per stage, so a lone item never blocks and three always do
      if (outstanding <= 1) begin
        assert (req_ready) else begin
          errors++;
          $display("[ERROR] %0t req_ready: got %b expected 1", $time, req_ready);
        end
      end else if (outstanding >= 3) begin
        assert (!req_ready) else begin
          errors++;
          $display("[ERROR] %0t req_ready: got %b expected 0", $time, req_ready);
        end
      end
      if (lat_armed && resp_valid) begin
        lat_armed = 1'b0;
        assert ((cycle - lat_start) == lat_expect) else begin
          errors++;
          $display("[ERROR] %0t resp_valid latency: got %0d expected %0d",
                   $time, cycle - lat_start, lat_expect);
        end
      end
      if (req_valid && req_ready) begin
        exp_res = model_div(req, fast);
        if (outstanding == 0) begin
          lat_armed  = 1'b1;  // Unit empty at this transfer
          lat_start  = cycle;
          lat_expect = fast ? 4 : 35;
        end
        exp_result_q.push_back(exp_res);
        exp_illegal_q.push_back(stim_q[cur_idx].exp_illegal);
        sent++;
        outstanding++;
      end
      if (resp_valid && resp_ready) begin
        assert (exp_result_q.size() != 0) else begin
          errors++;
          $display("%0t a response arrived with no request outstanding", $time);
        end
        if (exp_result_q.size() != 0) begin
          exp_res = exp_result_q.pop_front();
          exp_ill = exp_illegal_q.pop_front();
          assert (resp.result == exp_res) else begin
            errors++;
            $display("[ERROR] %0t resp.result: got %h expected %h", $time, resp.result, exp_res);
          end
          assert (resp.illegal == exp_ill) else begin
            errors++;
            $display("[ERROR] %0t resp.illegal: got %b expected %b",
                     $time, resp.illegal, exp_ill);
          end
        end
        received++;
        outstanding--;
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    repeat (RESET_CYCLES + stim_q.size() * 40 + 200) @(posedge CLK);
    $display("Timeout: the run did not complete, %0d of %0d responses seen",
             received, stim_q.size());
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
div_pkg.sv
div_decode.sv
div_iterative.sv
div_result.sv
divider_unit.sv
tb_divider_unit.sv

//--- Bender.yml
package:
  name: divider_unit

sources:
  - include_dirs:
      - .
    files:
      - div_pkg.sv
      - div_decode.sv
      - div_iterative.sv
      - div_result.sv
      - divider_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_divider_unit.sv
